/* src/hyperram_pkg.sv */
package hyperram_pkg;

	// upstream and bus widths
	localparam int DATA_W    = 32;
	localparam int ADDR_W    = 32;
	localparam int BYTE_W    = 8;

	// command-address word and burst sizes
	localparam int CA_W      = 48;
	localparam int CA_BYTES  = 6;
	localparam int MEM_BYTES = 4;
	localparam int REG_BYTES = 2;

	// latency setting and counters
	localparam int TACC_W    = 4;
	localparam int MIN_TACC  = 2;
	localparam int CNT_W     = 6;
	localparam int RD_CNT_W  = 3;

	// fixed bus timings, in clk_i cycles unless noted
	localparam int TCSH      = 4;
	localparam int TPRE      = 4;
	localparam int TPOST     = 4;
	// read timeout in bus clocks
	localparam int TRMAX     = 20;

	// bus phases, shared by sequencer, capture and transmit
	typedef enum logic [2:0] {
		IDLE,
		PRE,
		CA,
		LATENCY,
		WRITE,
		READ,
		POST
	} hb_phase_e;

	// bit 47 set means read transaction
	function automatic logic ca_is_read(input logic [CA_W-1:0] ca_word);
		return ca_word[CA_W-1];
	endfunction

	// bit 46 set means register space
	function automatic logic ca_is_reg(input logic [CA_W-1:0] ca_word);
		return ca_word[CA_W-2];
	endfunction

endpackage

/* src/hb_phase_if.sv */
interface hb_phase_if;
	import hyperram_pkg::*;

	// current bus phase and its cycle down-counter
	hb_phase_e             phase;
	logic [CNT_W-1:0]      cnt;
	// latched transfer words
	logic [CA_W-1:0]       ca;
	logic [DATA_W-1:0]     wdata;
	logic [MEM_BYTES-1:0]  sel;
	// read bytes still expected, and latency multiplier seen on RWDS during CA
	logic [RD_CNT_W-1:0]   rd_left;
	logic                  rwds_2x;

	modport seq (
		output phase, cnt, ca, wdata, sel,
		input  rd_left, rwds_2x
	);

	modport cap (
		input  phase, cnt, ca,
		output rd_left, rwds_2x
	);

	modport tx (
		input  phase, cnt, ca, wdata, sel, rd_left
	);

endinterface

/* src/hb_sequencer.sv */
module hb_sequencer (
	input  logic                                 clk_i,
	input  logic                                 rst_i,
	input  logic                                 valid_i,
	input  logic                                 wren_i,
	input  logic                                 regspace_i,
	input  logic [hyperram_pkg::ADDR_W-1:0]      addr_i,
	input  logic [hyperram_pkg::MEM_BYTES-1:0]   sel_i,
	input  logic [hyperram_pkg::DATA_W-1:0]      data_i,
	input  logic [hyperram_pkg::TACC_W-1:0]      tacc_i,
	input  logic                                 fixed_latency_i,
	input  logic                                 double_latency_i,
	output logic                                 ready_o,
	output logic                                 read_timeout_o,
	hb_phase_if.seq                              bus
);
	import hyperram_pkg::*;

	logic                 valid_q;
	logic                 valid_start;
	logic                 busy_q;

	// settings latched when a transfer leaves IDLE
	logic [TACC_W-1:0]    tacc_q;
	logic                 fixed_q;
	logic                 double_q;

	logic                 rd_op;
	logic                 reg_op;
	logic                 lat_2x;
	logic [CNT_W-1:0]     lat_cycles;

	// new request only on a rising valid
	assign valid_start = valid_i & ~valid_q;

	assign rd_op  = ca_is_read(bus.ca);
	assign reg_op = ca_is_reg(bus.ca);

	assign ready_o = ~busy_q;

	// fixed latency ignores what the device reports on RWDS
	assign lat_2x = fixed_q ? double_q : bus.rwds_2x;

	// 2*tacc*m - 2 for reads, one cycle less for writes
	always_comb begin
		lat_cycles = CNT_W'(tacc_q) << (lat_2x ? 2 : 1);
		lat_cycles = lat_cycles - CNT_W'(2) - CNT_W'(!rd_op);
	end

	always_ff @(posedge clk_i) begin
		if (rst_i) begin
			bus.phase      <= IDLE;
			bus.cnt        <= CNT_W'(TCSH);
			valid_q        <= 1'b0;
			busy_q         <= 1'b0;
			read_timeout_o <= 1'b0;
		end else begin
			valid_q <= valid_i;

			case (bus.phase)
				IDLE: begin
					// gap since the last transfer still running
					if (bus.cnt != '0) begin
						bus.cnt <= bus.cnt - 1'b1;
					end

					if (valid_start && !busy_q) begin
						busy_q         <= 1'b1;
						read_timeout_o <= 1'b0;
						bus.wdata      <= data_i;
						bus.sel        <= sel_i;
						// read flag, space, linear burst, then the split address
						bus.ca         <= {~wren_i, regspace_i, 1'b1, addr_i[31:3],
						                   13'h0000, addr_i[2:0]};
					end

					// start once the gap is over and a request waits
					if ((bus.cnt == '0) && (busy_q || valid_start)) begin
						bus.phase <= PRE;
						bus.cnt   <= CNT_W'(TPRE);
						tacc_q    <= (tacc_i < TACC_W'(MIN_TACC)) ? TACC_W'(MIN_TACC) : tacc_i;
						fixed_q   <= fixed_latency_i;
						double_q  <= double_latency_i;
					end
				end

				PRE: begin
					// chip select setup before the first bus clock edge
					if (bus.cnt != '0) begin
						bus.cnt <= bus.cnt - 1'b1;
					end else begin
						bus.phase <= CA;
						bus.cnt   <= CNT_W'(CA_BYTES - 1);
					end
				end

				CA: begin
					if (bus.cnt != '0) begin
						bus.cnt <= bus.cnt - 1'b1;
					end else if (!rd_op && reg_op) begin
						// register writes have no latency
						bus.phase <= WRITE;
						bus.cnt   <= CNT_W'(REG_BYTES - 1);
					end else begin
						bus.phase <= LATENCY;
						bus.cnt   <= lat_cycles;
					end
				end

				LATENCY: begin
					if (bus.cnt != '0) begin
						bus.cnt <= bus.cnt - 1'b1;
					end else if (rd_op) begin
						// counter now doubles as the read timeout
						bus.phase <= READ;
						bus.cnt   <= CNT_W'(2 * TRMAX - 2);
					end else begin
						bus.phase <= WRITE;
						bus.cnt   <= CNT_W'(MEM_BYTES - 1);
					end
				end

				WRITE: begin
					if (bus.cnt != '0) begin
						bus.cnt <= bus.cnt - 1'b1;
					end else begin
						bus.phase <= POST;
						bus.cnt   <= CNT_W'(TPOST);
					end
				end

				READ: begin
					// done when every byte arrived, or the device never strobed
					if ((bus.cnt == '0) || (bus.rd_left == '0)) begin
						bus.phase      <= POST;
						bus.cnt        <= CNT_W'(TPOST);
						read_timeout_o <= (bus.cnt == '0) && (bus.rd_left != '0);
					end else begin
						bus.cnt <= bus.cnt - 1'b1;
					end
				end

				POST: begin
					// chip select hold after the last clock edge
					if (bus.cnt != '0) begin
						bus.cnt <= bus.cnt - 1'b1;
					end else begin
						bus.phase <= IDLE;
						bus.cnt   <= CNT_W'(TCSH);
						busy_q    <= 1'b0;
					end
				end

				default: begin
					bus.phase <= IDLE;
					bus.cnt   <= CNT_W'(TCSH);
				end
			endcase
		end
	end

endmodule

/* src/hb_read_capture.sv */
module hb_read_capture (
	input  logic                              clk_i,
	input  logic                              rst_i,
	input  logic                              hb_rwds_i,
	input  logic [hyperram_pkg::BYTE_W-1:0]   hb_dq_i,
	output logic [hyperram_pkg::DATA_W-1:0]   data_o,
	hb_phase_if.cap                           bus
);
	import hyperram_pkg::*;

	// RWDS from the previous falling edge qualifies odd bytes
	logic rwds_q;
	logic byte_valid;

	// even count takes the byte on RWDS high, odd count on the prior high level
	assign byte_valid = (hb_rwds_i && !bus.rd_left[0]) || (rwds_q && bus.rd_left[0]);

	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			bus.rd_left <= '0;
			bus.rwds_2x <= 1'b1;
			rwds_q      <= 1'b0;
			data_o      <= '0;
		end else begin
			case (bus.phase)
				IDLE: begin
					// device default is double latency
					bus.rwds_2x <= 1'b1;
				end

				PRE: begin
					data_o <= '0;
				end

				CA: begin
					// RWDS on the third CA byte tells the latency multiplier
					if (bus.cnt == CNT_W'(CA_BYTES - 3)) begin
						bus.rwds_2x <= hb_rwds_i;
						if (ca_is_reg(bus.ca)) begin
							bus.rd_left <= RD_CNT_W'(REG_BYTES);
						end else begin
							bus.rd_left <= RD_CNT_W'(MEM_BYTES);
						end
					end
				end

				READ: begin
					rwds_q <= hb_rwds_i;
					if (byte_valid && (bus.rd_left != '0)) begin
						bus.rd_left <= bus.rd_left - 1'b1;
						// first byte lands in the top lane of the burst
						data_o[(int'(bus.rd_left) - 1) * BYTE_W +: BYTE_W] <= hb_dq_i;
					end
				end

				default: begin
					rwds_q <= 1'b0;
				end
			endcase
		end
	end

endmodule

/* src/hb_tx_path.sv */
module hb_tx_path (
	input  logic                              clk_i,
	input  logic                              rst_i,
	output logic                              hb_clk_o,
	output logic                              hb_clkn_o,
	output logic                              hb_rwds_o,
	output logic                              hb_rwds_oen,
	output logic [hyperram_pkg::BYTE_W-1:0]   hb_dq_o,
	output logic                              hb_dq_oen,
	hb_phase_if.tx                            bus
);
	import hyperram_pkg::*;

	logic clk_active;
	logic mem_write;

	// the last read clock is not needed once fewer than two bytes remain
	assign clk_active = (bus.phase == CA) || (bus.phase == LATENCY) ||
	                    (bus.phase == WRITE) ||
	                    ((bus.phase == READ) && (bus.rd_left >= RD_CNT_W'(2)));

	assign mem_write = (bus.phase == WRITE) && !ca_is_reg(bus.ca);

	// bus clock changes on the falling edge, centred on the data
	always_ff @(negedge clk_i) begin
		if (rst_i) begin
			hb_clk_o <= 1'b0;
		end else begin
			hb_clk_o <= clk_active ? ~hb_clk_o : 1'b0;
		end
	end

	assign hb_clkn_o = ~hb_clk_o;

	// DQ byte picked by the phase counter, most significant byte first
	always_comb begin
		hb_dq_o = '0;
		case (bus.phase)
			CA: begin
				if (bus.cnt < CNT_W'(CA_BYTES)) begin
					hb_dq_o = bus.ca[int'(bus.cnt) * BYTE_W +: BYTE_W];
				end
			end
			WRITE: begin
				if (bus.cnt < CNT_W'(MEM_BYTES)) begin
					hb_dq_o = bus.wdata[int'(bus.cnt) * BYTE_W +: BYTE_W];
				end
			end
			default: begin
				hb_dq_o = '0;
			end
		endcase
	end

	assign hb_dq_oen = !((bus.phase == CA) || (bus.phase == WRITE));

	// RWDS is the byte mask on memory writes, otherwise left to the device
	assign hb_rwds_oen = !mem_write;
	assign hb_rwds_o   = (mem_write && (bus.cnt < CNT_W'(MEM_BYTES))) ?
	                     ~bus.sel[int'(bus.cnt)] : 1'b0;

endmodule

/* src/hyperram.sv */
module hyperram (
	input  logic                                 clk_i,
	input  logic                                 rst_i,
	// upstream request port
	input  logic                                 valid_i,
	input  logic                                 wren_i,
	input  logic                                 regspace_i,
	input  logic [hyperram_pkg::ADDR_W-1:0]      addr_i,
	input  logic [hyperram_pkg::MEM_BYTES-1:0]   sel_i,
	input  logic [hyperram_pkg::DATA_W-1:0]      data_i,
	output logic                                 ready_o,
	output logic [hyperram_pkg::DATA_W-1:0]      data_o,
	output logic                                 read_timeout_o,
	// latency settings, latched per transfer
	input  logic [hyperram_pkg::TACC_W-1:0]      tacc_i,
	input  logic                                 fixed_latency_i,
	input  logic                                 double_latency_i,
	// HyperBus pins
	output logic                                 hb_rstn_o,
	output logic                                 hb_csn_o,
	output logic                                 hb_clk_o,
	output logic                                 hb_clkn_o,
	output logic                                 hb_rwds_o,
	output logic                                 hb_rwds_oen,
	output logic [hyperram_pkg::BYTE_W-1:0]      hb_dq_o,
	output logic                                 hb_dq_oen,
	input  logic                                 hb_rwds_i,
	input  logic [hyperram_pkg::BYTE_W-1:0]      hb_dq_i
);
	import hyperram_pkg::*;

	hb_phase_if bus ();

	hb_sequencer u_seq (
		.clk_i            (clk_i),
		.rst_i            (rst_i),
		.valid_i          (valid_i),
		.wren_i           (wren_i),
		.regspace_i       (regspace_i),
		.addr_i           (addr_i),
		.sel_i            (sel_i),
		.data_i           (data_i),
		.tacc_i           (tacc_i),
		.fixed_latency_i  (fixed_latency_i),
		.double_latency_i (double_latency_i),
		.ready_o          (ready_o),
		.read_timeout_o   (read_timeout_o),
		.bus              (bus.seq)
	);

	hb_read_capture u_cap (
		.clk_i     (clk_i),
		.rst_i     (rst_i),
		.hb_rwds_i (hb_rwds_i),
		.hb_dq_i   (hb_dq_i),
		.data_o    (data_o),
		.bus       (bus.cap)
	);

	hb_tx_path u_tx (
		.clk_i       (clk_i),
		.rst_i       (rst_i),
		.hb_clk_o    (hb_clk_o),
		.hb_clkn_o   (hb_clkn_o),
		.hb_rwds_o   (hb_rwds_o),
		.hb_rwds_oen (hb_rwds_oen),
		.hb_dq_o     (hb_dq_o),
		.hb_dq_oen   (hb_dq_oen),
		.bus         (bus.tx)
	);

	// chip select active for the whole transfer
	assign hb_csn_o  = (bus.phase == IDLE);
	assign hb_rstn_o = ~rst_i;

endmodule

/* verification/hyperram_checker.sv */
module hyperram_checker (
	input logic clk_i,
	input logic rst_i,
	input logic ready_o,
	input logic hb_csn_o,
	input logic hb_clk_o,
	input logic hb_clkn_o,
	input logic hb_dq_oen,
	input logic hb_rwds_oen
);
	timeunit 1ns;
	timeprecision 100ps;

	// number of failed assertions
	int err_count = 0;

	// deselected bus drives nothing and keeps the clock low
	idle_bus_a: assert property (@(posedge clk_i) disable iff (rst_i)
		hb_csn_o |-> (hb_dq_oen && hb_rwds_oen && !hb_clk_o))
	else begin
		$error("bus driven or clocked while chip select is high");
		err_count++;
	end

	diff_clk_a: assert property (@(posedge clk_i) disable iff (rst_i)
		hb_clkn_o == !hb_clk_o)
	else begin
		$error("hb_clkn_o is not the inverse of hb_clk_o");
		err_count++;
	end

	// no new request accepted during a transfer
	busy_a: assert property (@(posedge clk_i) disable iff (rst_i)
		!hb_csn_o |-> !ready_o)
	else begin
		$error("ready_o high while chip select is low");
		err_count++;
	end

endmodule

bind hyperram hyperram_checker u_checker (.*);

/* verification/tb_hyperram.sv */
module tb_hyperram;
	timeunit 1ns;
	timeprecision 100ps;
	import hyperram_pkg::*;

	localparam int TIMEOUT_CYCLES = 400;

	logic                 clk_i = 1'b0;
	logic                 rst_i, valid_i, wren_i, regspace_i;
	logic [ADDR_W-1:0]    addr_i;
	logic [MEM_BYTES-1:0] sel_i;
	logic [DATA_W-1:0]    data_i, data_o;
	logic [TACC_W-1:0]    tacc_i;
	logic                 fixed_latency_i, double_latency_i, ready_o, read_timeout_o;
	logic                 hb_rstn_o, hb_csn_o, hb_clk_o, hb_clkn_o;
	logic                 hb_rwds_o, hb_rwds_oen, hb_dq_oen, hb_rwds_i;
	logic [BYTE_W-1:0]    hb_dq_o, hb_dq_i;

	int seed = 32'h465db8ba;

	// device model state for the CA shift register, write bytes and read response
	logic [CA_W-1:0]      ca_seen;
	int                   n_ca = 0, lat_edges = 0, rd_idx = 0, rd_bytes = 0, rd_lat = 0;
	logic [BYTE_W-1:0]    wr_bytes[$];
	logic                 wr_rwds[$];
	logic                 rwds_en_seen, ca_rwds = 1'b0;
	logic [DATA_W-1:0]    rd_word, cur_data, cur_addr;
	logic [MEM_BYTES-1:0] cur_sel;

	always #50 clk_i = ~clk_i;

	hyperram u_hyperram (.*);

	// device side, sampled on every bus clock edge
	always @(hb_clk_o) begin
		if (!hb_csn_o && !hb_rwds_oen) rwds_en_seen = 1'b1;
		if (!hb_csn_o && !hb_dq_oen) begin
			if (n_ca < CA_BYTES) begin
				ca_seen = {ca_seen[CA_W-BYTE_W-1:0], hb_dq_o};
				n_ca++;
			end else begin
				wr_bytes.push_back(hb_dq_o);
				wr_rwds.push_back(hb_rwds_o);
			end
		end else if (!hb_csn_o && n_ca == CA_BYTES) begin
			lat_edges++;
		end
	end

	// RWDS level during CA, then read bytes once the latency edges have passed
	always @(posedge clk_i) begin
		if (hb_csn_o) begin
			hb_rwds_i <= 1'b0;
		end else if (n_ca < CA_BYTES) begin
			hb_rwds_i <= ca_rwds;
		end else if (lat_edges >= rd_lat && rd_idx < rd_bytes) begin
			hb_dq_i   <= rd_word[DATA_W-1-BYTE_W*rd_idx -: BYTE_W];
			hb_rwds_i <= (rd_idx % 2 == 0);
			rd_idx++;
		end else begin
			hb_rwds_i <= 1'b0;
		end
	end

	// stop at the first failed bus assertion
	always @(u_hyperram.u_checker.err_count) begin
		if (u_hyperram.u_checker.err_count != 0) begin
			$display("bus protocol assertion failed at %0t", $time);
			$display("RESULT: FAIL");
			$fatal(1, "bus assertion failed");
		end
	end

	task automatic report_mismatch(input string msg);
		$display("ERR @%0t: %s", $time, msg);
		$display("RESULT: FAIL");
		$fatal(1, "check failed");
	endtask

	task automatic abort_on_timeout();
		$display("ready_o did not return within %0d cycles of a request", TIMEOUT_CYCLES);
		$display("RESULT: FAIL");
		$fatal(1, "timeout");
	endtask

	// one request with random address, data, mask and latency, then wait for ready_o
	task automatic run_transfer(input logic wr, input logic rs, input logic rwds_lvl,
	                            input logic fixed, input logic dbl, input int nrd);
		int cycles;
		int t;
		logic [TACC_W-1:0] tacc;
		logic [CA_W-1:0] ca_exp;
		n_ca = 0;
		lat_edges = 0;
		rd_idx = 0;
		rd_bytes = nrd;
		ca_rwds = rwds_lvl;
		rwds_en_seen = 1'b0;
		wr_bytes.delete();
		wr_rwds.delete();
		rd_word = $random(seed);
		cur_addr = $random(seed);
		cur_data = $random(seed);
		cur_sel = MEM_BYTES'($random(seed));
		tacc = TACC_W'($random(seed));
		t = (tacc < MIN_TACC) ? MIN_TACC : int'(tacc);
		rd_lat = 2 * t * ((fixed ? dbl : rwds_lvl) ? 2 : 1);
		@(posedge clk_i);
		valid_i          <= 1'b1;
		wren_i           <= wr;
		regspace_i       <= rs;
		addr_i           <= cur_addr;
		data_i           <= cur_data;
		sel_i            <= cur_sel;
		tacc_i           <= tacc;
		fixed_latency_i  <= fixed;
		double_latency_i <= dbl;
		@(posedge clk_i);
		valid_i <= 1'b0;
		cycles = 0;
		do begin
			@(negedge clk_i);
			cycles++;
			if (cycles > TIMEOUT_CYCLES) abort_on_timeout();
		end while (!ready_o);
		ca_exp = {~wr, rs, 1'b1, cur_addr[31:3], 13'h0000, cur_addr[2:0]};
		assert (n_ca == CA_BYTES && ca_seen == ca_exp)
		else report_mismatch($sformatf("CA %h (%0d bytes), expected %h",
		                               ca_seen, n_ca, ca_exp));
	endtask

	task automatic check_reset();
		repeat (2) begin
			@(negedge clk_i);
			assert (!hb_rstn_o) else report_mismatch("hb_rstn_o high during reset");
		end
		@(posedge clk_i);
		rst_i <= 1'b0;
		@(negedge clk_i);
		assert (hb_csn_o && hb_dq_oen && hb_rwds_oen && !hb_clk_o &&
		        ready_o && !read_timeout_o)
		else report_mismatch("bus or status outputs not idle after reset");
	endtask

	task automatic memory_write();
		run_transfer(1'b1, 1'b0, 1'b0, 1'b1, 1'b0, 0);
		assert (wr_bytes.size() == MEM_BYTES)
		else report_mismatch("memory write byte count");
		assert (rwds_en_seen) else report_mismatch("RWDS not driven during a memory write");
		for (int i = 0; i < MEM_BYTES; i++) begin
			assert (wr_bytes[i] == cur_data[DATA_W-1-BYTE_W*i -: BYTE_W] &&
			        wr_rwds[i] == !cur_sel[MEM_BYTES-1-i])
			else report_mismatch($sformatf("write byte %0d is %h rwds %b",
			                               i, wr_bytes[i], wr_rwds[i]));
		end
	endtask

	task automatic register_write();
		run_transfer(1'b1, 1'b1, 1'b0, 1'b0, 1'b0, 0);
		assert (ca_is_reg(ca_seen))
		else report_mismatch("CA bit 46 clear on a register write");
		assert (wr_bytes.size() == REG_BYTES && wr_bytes[0] == cur_data[15:8] &&
		        wr_bytes[1] == cur_data[7:0])
		else report_mismatch($sformatf("register write data, expected %h", cur_data[15:0]));
		assert (!rwds_en_seen) else report_mismatch("RWDS driven during a register write");
	endtask

	// register reads land in the low half of data_o
	task automatic compare_read(input logic rs, input logic rwds_lvl, input logic fixed,
	                            input logic dbl);
		logic [DATA_W-1:0] exp;
		run_transfer(1'b0, rs, rwds_lvl, fixed, dbl, rs ? REG_BYTES : MEM_BYTES);
		exp = rs ? {16'h0000, rd_word[31:16]} : rd_word;
		assert (data_o == exp && !read_timeout_o)
		else report_mismatch($sformatf("read data %h timeout %b, expected %h", data_o,
		                               read_timeout_o, exp));
	endtask

	task automatic timeout_read();
		run_transfer(1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 0);
		assert (read_timeout_o) else report_mismatch("read_timeout_o low without any strobe");
		compare_read(1'b0, 1'b1, 1'b1, 1'b0);
	endtask

	initial begin
		rst_i = 1'b1;
		valid_i = 1'b0;
		wren_i = 1'b0;
		regspace_i = 1'b0;
		addr_i = '0;
		sel_i = '0;
		data_i = '0;
		tacc_i = '0;
		fixed_latency_i = 1'b0;
		double_latency_i = 1'b0;
		hb_rwds_i = 1'b0;
		hb_dq_i = '0;
		check_reset();
		memory_write();
		register_write();
		// variable latency with RWDS high, then low, then fixed double latency
		compare_read(1'b0, 1'b1, 1'b0, 1'b0);
		compare_read(1'b0, 1'b0, 1'b0, 1'b1);
		compare_read(1'b0, 1'b0, 1'b1, 1'b1);
		compare_read(1'b1, 1'b1, 1'b0, 1'b0);
		timeout_read();
		@(negedge clk_i);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* src.f */
src/hyperram_pkg.sv
src/hb_phase_if.sv
src/hb_sequencer.sv
src/hb_read_capture.sv
src/hb_tx_path.sv
src/hyperram.sv
verification/hyperram_checker.sv
verification/tb_hyperram.sv

/* Bender.yml */
package:
  name: hyperram

sources:
  - src/hyperram_pkg.sv
  - src/hb_phase_if.sv
  - src/hb_sequencer.sv
  - src/hb_read_capture.sv
  - src/hb_tx_path.sv
  - src/hyperram.sv
  - target: test
    files:
      - verification/hyperram_checker.sv
      - verification/tb_hyperram.sv
